// File: files.f
+incdir+verilog
verilog/fft_tribuf_pkg.sv
verilog/bank_bus_if.sv
verilog/frame_bank.sv
verilog/stream_capture.sv
verilog/tribuf_rotation.sv
verilog/fft_tribuf_top.sv
verif/tb_clock_gen.sv
verif/fft_tribuf_asserts.sv
verif/fft_tribuf_tb.sv

// File: verif/fft_tribuf_asserts.sv
// concurrent assertions on the run handshake, rotate pulse and capture state encoding
`timescale 1ns/1ps
`default_nettype none

module fft_tribuf_asserts (
   input wire       clk,
   input wire       rst,
   input wire       run_req,
   input wire       run_ack,
   input wire       rotate,
   input wire [1:0] ibuf_state
);

   // ack may only rise in answer to a request
   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(run_ack) |-> $past(run_req))
      else $error("run_ack rose without run_req");

   // three states only, encoding 3 is unused
   state_encoding: assert property (@(posedge clk) disable iff (rst)
      ibuf_state != 2'd3)
      else $error("ibuf_state holds the unused encoding 3");

   rotate_gives_ack: assert property (@(posedge clk) disable iff (rst)
      rotate |=> $rose(run_ack))
      else $error("rotate pulse not followed by rising run_ack");

   ack_from_rotate: assert property (@(posedge clk) disable iff (rst)
      $rose(run_ack) |-> $past(rotate))
      else $error("run_ack rose without a rotate pulse");

endmodule

`default_nettype wire

// File: verif/fft_tribuf_tb.sv
// testbench for the fft triple buffer, table-driven frames checked against a slot model
`timescale 1ns/1ps
`default_nettype none
`include "fft_tribuf_settings.svh"

module fft_tribuf_tb;

   localparam int FRAME_LEN   = 1 << `FFT_N;
   localparam int NUM_ENTRIES = 7;
   localparam int WAIT_LIMIT  = 20;

   wire                  clk;
   wire                  rst;
   logic                 run_req;
   logic                 in_valid;
   logic [`FFT_DW-1:0]   in_real;
   logic [`FFT_DW-1:0]   in_imag;
   logic                 dma_en;
   logic [`FFT_N-1:0]    dma_addr;
   wire                  run_ack;
   wire [1:0]            ibuf_state;
   wire [`FFT_DW-1:0]    dma_real;
   wire [`FFT_DW-1:0]    dma_imag;
   wire [`FFT_BWDW-1:0]  frame_bw;

   // name, sample mask, forced bits, samples sent past a full frame
   string              entry_name  [NUM_ENTRIES] = '{"zero_frame", "small_pos", "small_neg",
      "mid_range", "full_random", "neg_full_scale", "near_full_pos"};
   logic [`FFT_DW-1:0] entry_mask  [NUM_ENTRIES] = '{16'h0000, 16'h0007, 16'h000f,
      16'h03ff, 16'hffff, 16'h0000, 16'h7fff};
   logic [`FFT_DW-1:0] entry_fill  [NUM_ENTRIES] = '{16'h0000, 16'h0000, 16'hfff0,
      16'h0000, 16'h0000, 16'h8000, 16'h0000};
   int                 entry_extra [NUM_ENTRIES] = '{0, 2, 0, 3, 0, 1, 0};

   // reference slots, capture -> hold -> readout
   logic [2*`FFT_DW-1:0] cap_word  [FRAME_LEN];
   logic [2*`FFT_DW-1:0] hold_word [FRAME_LEN];
   logic [2*`FFT_DW-1:0] read_word [FRAME_LEN];
   int                   cap_bw;
   int                   hold_bw;
   int                   read_bw;
   bit                   cap_valid;
   bit                   hold_valid;
   bit                   read_valid;
   string                cap_name;
   string                hold_name;
   string                read_name;

   logic [31:0] lcg_state;
   int          mismatch_count;
   int          timeout_count;
   bit          hung;

   tb_clock_gen tb_clock_gen_inst (
      .clk (clk),
      .rst (rst)
   );

   fft_tribuf_top fft_tribuf_top_inst (
      .clk        (clk),
      .rst        (rst),
      .run_req    (run_req),
      .in_valid   (in_valid),
      .in_real    (in_real),
      .in_imag    (in_imag),
      .dma_en     (dma_en),
      .dma_addr   (dma_addr),
      .run_ack    (run_ack),
      .ibuf_state (ibuf_state),
      .dma_real   (dma_real),
      .dma_imag   (dma_imag),
      .frame_bw   (frame_bw)
   );

   bind fft_tribuf_top fft_tribuf_asserts fft_tribuf_asserts_inst (
      .clk        (clk),
      .rst        (rst),
      .run_req    (run_req),
      .run_ack    (run_ack),
      .rotate     (rotate),
      .ibuf_state (ibuf_state)
   );

   //////////////////////////////////////////////////////////////////////
   // reference helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   function automatic int bit_reverse(input int k);
      int r;
      r = 0;
      for (int i = 0; i < `FFT_N; i++) begin
         r = (r << 1) | ((k >> i) & 1);
      end
      return r;
   endfunction

   // smallest n with -2^(n-1) <= v <= 2^(n-1)-1
   function automatic int signed_width(input logic signed [`FFT_DW-1:0] v);
      int val;
      int w;
      val = v;
      w = `FFT_DW;
      for (int n = `FFT_DW; n >= 1; n--) begin
         if (val >= -(1 << (n - 1)) && val <= (1 << (n - 1)) - 1) begin
            w = n;
         end
      end
      return w;
   endfunction

   task automatic report_mismatch(input string test, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
      mismatch_count++;
      $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
   endtask

   task automatic rotate_model();
      read_word  = hold_word;
      read_bw    = hold_bw;
      read_valid = hold_valid;
      read_name  = hold_name;
      hold_word  = cap_word;
      hold_bw    = cap_bw;
      hold_valid = cap_valid;
      hold_name  = cap_name;
      cap_bw     = 0;
      cap_valid  = 1'b0;
      cap_name   = "empty";
   endtask

   //////////////////////////////////////////////////////////////////////
   // waits, each with its own timeout
   //////////////////////////////////////////////////////////////////////

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst !== 1'b0 && n < WAIT_LIMIT) begin
         @(negedge clk or negedge rst);
         n++;
      end
      if (rst !== 1'b0) begin
         $display("timeout: reset was never released");
         timeout_count++;
         hung = 1'b1;
      end
   endtask

   task automatic wait_stream();
      int n;
      n = 0;
      while (ibuf_state !== fft_tribuf_pkg::IBUF_STREAM && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (ibuf_state !== fft_tribuf_pkg::IBUF_STREAM) begin
         $display("timeout: capture never entered the streaming state");
         timeout_count++;
         hung = 1'b1;
      end
   endtask

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (run_ack !== level && n < WAIT_LIMIT);
      if (run_ack !== level) begin
         $display("timeout: run_ack did not go to %b", level);
         timeout_count++;
         hung = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic capture_frame(input int e);
      logic [`FFT_DW-1:0] re;
      logic [`FFT_DW-1:0] im;
      int                 w;
      if (ibuf_state !== fft_tribuf_pkg::IBUF_STREAM) begin
         report_mismatch(entry_name[e], "state at start", fft_tribuf_pkg::IBUF_STREAM,
                         ibuf_state);
      end
      cap_bw = 0;
      for (int k = 0; k < FRAME_LEN + entry_extra[e]; k++) begin
         re = (lcg_next() & entry_mask[e]) | entry_fill[e];
         im = (lcg_next() & entry_mask[e]) | entry_fill[e];
         @(negedge clk);
         in_valid = 1'b1;
         in_real  = re;
         in_imag  = im;
         // samples past a full frame are dropped by the design
         if (k < FRAME_LEN) begin
            cap_word[bit_reverse(k)] = {im, re};
            w = signed_width(re);
            cap_bw = (w > cap_bw) ? w : cap_bw;
            w = signed_width(im);
            cap_bw = (w > cap_bw) ? w : cap_bw;
         end
      end
      @(negedge clk);
      in_valid  = 1'b0;
      cap_valid = 1'b1;
      cap_name  = entry_name[e];
      if (ibuf_state !== fft_tribuf_pkg::IBUF_FULL) begin
         report_mismatch(entry_name[e], "state when full", fft_tribuf_pkg::IBUF_FULL,
                         ibuf_state);
      end
   endtask

   task automatic run_handshake(input string test);
      @(negedge clk);
      if (run_ack !== 1'b0) begin
         report_mismatch(test, "run_ack before req", 32'd0, run_ack);
      end
      run_req = 1'b1;
      wait_ack(1'b1);
      if (!hung) begin
         @(negedge clk);
         if (run_ack !== 1'b1) begin
            report_mismatch(test, "run_ack while req held", 32'd1, run_ack);
         end
         run_req = 1'b0;
         wait_ack(1'b0);
      end
   endtask

   // address a on one edge, word checked one cycle later
   task automatic check_readout();
      logic [2*`FFT_DW-1:0] got;
      for (int a = 0; a <= FRAME_LEN; a++) begin
         @(negedge clk);
         if (a > 0) begin
            got = {dma_imag, dma_real};
            if (got !== read_word[a-1]) begin
               report_mismatch(read_name, $sformatf("dma word %0d", a - 1), read_word[a-1], got);
            end
         end
         dma_en   = (a < FRAME_LEN);
         dma_addr = a[`FFT_N-1:0];
      end
      dma_en = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      run_req        = 1'b0;
      in_valid       = 1'b0;
      in_real        = '0;
      in_imag        = '0;
      dma_en         = 1'b0;
      dma_addr       = '0;
      lcg_state      = 32'd25173;
      mismatch_count = 0;
      timeout_count  = 0;
      hung           = 1'b0;
      cap_bw         = 0;
      hold_bw        = 0;
      read_bw        = 0;
      cap_valid      = 1'b0;
      hold_valid     = 1'b0;
      read_valid     = 1'b0;
      cap_name       = "empty";
      hold_name      = "empty";
      read_name      = "empty";

      wait_reset_release();
      if (!hung) begin
         if (ibuf_state !== fft_tribuf_pkg::IBUF_IDLE) begin
            report_mismatch("reset", "ibuf_state", fft_tribuf_pkg::IBUF_IDLE, ibuf_state);
         end
         wait_stream();
      end
      if (!hung) begin
         if (run_ack !== 1'b0) begin
            report_mismatch("reset", "run_ack", 32'd0, run_ack);
         end
         if (frame_bw !== '0) begin
            report_mismatch("reset", "frame_bw", 32'd0, frame_bw);
         end
      end

      // two extra runs push the last frames out to the readout bank
      for (int e = 0; e < NUM_ENTRIES + 2 && !hung; e++) begin
         if (e < NUM_ENTRIES) begin
            capture_frame(e);
         end
         run_handshake((e < NUM_ENTRIES) ? entry_name[e] : "flush");
         if (!hung) begin
            rotate_model();
            if (frame_bw !== read_bw[`FFT_BWDW-1:0]) begin
               report_mismatch(read_name, "frame_bw", read_bw, frame_bw);
            end
            if (read_valid) begin
               check_readout();
            end
         end
      end

      $display("mismatches %0d, timeouts %0d", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// testbench clock and reset generator, 20 ns clock with reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// File: verilog/bank_bus_if.sv
// bank bus carrying the write and read ports of one frame bank
`timescale 1ns/1ps
`default_nettype none

interface bank_bus_if;

   logic                   we;
   fft_tribuf_pkg::addr_t  waddr;
   fft_tribuf_pkg::cword_t wdata;
   fft_tribuf_pkg::addr_t  raddr;
   fft_tribuf_pkg::cword_t rdata;

   // routing side
   modport ctrl (
      output we,
      output waddr,
      output wdata,
      output raddr,
      input  rdata
   );

   // memory side
   modport bank (
      input  we,
      input  waddr,
      input  wdata,
      input  raddr,
      output rdata
   );

endinterface

`default_nettype wire

// File: verilog/fft_tribuf_pkg.sv
// fft triple buffer types shared by capture, rotation and banks
`default_nettype none
`include "fft_tribuf_settings.svh"

package fft_tribuf_pkg;

   // one signed part of a complex sample
   typedef logic signed [`FFT_DW-1:0] sample_t;

   // stored word, imag in the upper half
   typedef logic [2*`FFT_DW-1:0] cword_t;

   typedef logic [`FFT_N-1:0] addr_t;

   // signed bit width of a value or a frame
   typedef logic [`FFT_BWDW-1:0] bw_t;

   // bank role rotation
   typedef enum logic [1:0] {
      PHASE_0,
      PHASE_1,
      PHASE_2
   } phase_t;

   typedef enum logic [1:0] {
      IBUF_IDLE   = 2'd0,
      IBUF_STREAM = 2'd1,
      IBUF_FULL   = 2'd2
   } ibuf_state_t;

endpackage

`default_nettype wire

// File: verilog/fft_tribuf_settings.svh
// fft triple buffer settings for frame length, sample width and bit-width field
`ifndef FFT_TRIBUF_SETTINGS_SVH
`define FFT_TRIBUF_SETTINGS_SVH

// log2 of the frame length
`define FFT_N 4

// one real or imaginary part
`define FFT_DW 16

// holds a bit width up to FFT_DW
`define FFT_BWDW 5

`endif

// File: verilog/fft_tribuf_top.sv
// fft triple buffer top joining stream capture, bank rotation and three frame banks
`timescale 1ns/1ps
`default_nettype none

module fft_tribuf_top (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              run_req,
   input  wire                              in_valid,
   input  wire fft_tribuf_pkg::sample_t     in_real,
   input  wire fft_tribuf_pkg::sample_t     in_imag,
   input  wire                              dma_en,
   input  wire fft_tribuf_pkg::addr_t       dma_addr,
   output wire                              run_ack,
   output wire fft_tribuf_pkg::ibuf_state_t ibuf_state,
   output wire fft_tribuf_pkg::sample_t     dma_real,
   output wire fft_tribuf_pkg::sample_t     dma_imag,
   output wire fft_tribuf_pkg::bw_t         frame_bw
);

   wire                         rotate;
   wire                         wr_en;
   wire fft_tribuf_pkg::addr_t  wr_addr;
   wire fft_tribuf_pkg::cword_t wr_data;
   wire fft_tribuf_pkg::bw_t    frame_bw_cap;

   bank_bus_if bank_bus0 ();
   bank_bus_if bank_bus1 ();
   bank_bus_if bank_bus2 ();

   stream_capture stream_capture_inst (
      .clk          (clk),
      .rst          (rst),
      .rotate       (rotate),
      .in_valid     (in_valid),
      .in_real      (in_real),
      .in_imag      (in_imag),
      .ibuf_state   (ibuf_state),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .frame_bw_cap (frame_bw_cap)
   );

   tribuf_rotation tribuf_rotation_inst (
      .clk          (clk),
      .rst          (rst),
      .run_req      (run_req),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .frame_bw_cap (frame_bw_cap),
      .dma_en       (dma_en),
      .dma_addr     (dma_addr),
      .run_ack      (run_ack),
      .rotate       (rotate),
      .dma_real     (dma_real),
      .dma_imag     (dma_imag),
      .frame_bw     (frame_bw),
      .bank0        (bank_bus0.ctrl),
      .bank1        (bank_bus1.ctrl),
      .bank2        (bank_bus2.ctrl)
   );

   frame_bank frame_bank0_inst (
      .clk (clk),
      .bus (bank_bus0.bank)
   );

   frame_bank frame_bank1_inst (
      .clk (clk),
      .bus (bank_bus1.bank)
   );

   frame_bank frame_bank2_inst (
      .clk (clk),
      .bus (bank_bus2.bank)
   );

endmodule

`default_nettype wire

// File: verilog/frame_bank.sv
// frame bank holding one frame of complex words, synchronous write, registered read
`timescale 1ns/1ps
`default_nettype none
`include "fft_tribuf_settings.svh"

module frame_bank (
   input wire       clk,
   bank_bus_if.bank bus
);

   localparam int DEPTH = 1 << `FFT_N;

   fft_tribuf_pkg::cword_t mem [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (bus.we) begin
         mem[bus.waddr] <= bus.wdata;
      end
   end

   // read every cycle, word appears one cycle later
   always_ff @(posedge clk) begin
      bus.rdata <= mem[bus.raddr];
   end

endmodule

`default_nettype wire

// File: verilog/stream_capture.sv
// stream capture writing one frame in bit-reversed order and tracking its bit width
`timescale 1ns/1ps
`default_nettype none
`include "fft_tribuf_settings.svh"

module stream_capture (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          rotate,
   input  wire                          in_valid,
   input  wire fft_tribuf_pkg::sample_t in_real,
   input  wire fft_tribuf_pkg::sample_t in_imag,
   output fft_tribuf_pkg::ibuf_state_t  ibuf_state,
   output logic                         wr_en,
   output fft_tribuf_pkg::addr_t        wr_addr,
   output fft_tribuf_pkg::cword_t       wr_data,
   output fft_tribuf_pkg::bw_t          frame_bw_cap
);

   fft_tribuf_pkg::ibuf_state_t state;
   fft_tribuf_pkg::ibuf_state_t state_next;
   fft_tribuf_pkg::addr_t       count;
   fft_tribuf_pkg::bw_t         real_bw;
   fft_tribuf_pkg::bw_t         imag_bw;
   fft_tribuf_pkg::bw_t         sample_bw;
   fft_tribuf_pkg::bw_t         max_bw;
   logic                        last;

   // smallest two's complement width that holds v, 0 and -1 give 1
   function automatic fft_tribuf_pkg::bw_t bit_width(fft_tribuf_pkg::sample_t v);
      logic [`FFT_DW-1:0]  mag;
      fft_tribuf_pkg::bw_t w;
      mag = v[`FFT_DW-1] ? ~v : v;
      w = fft_tribuf_pkg::bw_t'(1);
      for (int i = 0; i < `FFT_DW - 1; i++) begin
         if (mag[i]) begin
            w = fft_tribuf_pkg::bw_t'(i + 2);
         end
      end
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // capture state machine
   //////////////////////////////////////////////////////////////////////

   assign ibuf_state = state;
   assign wr_en      = in_valid && (state == fft_tribuf_pkg::IBUF_STREAM);
   assign last       = wr_en && (count == '1);

   always_comb begin
      state_next = state;
      case (state)
         fft_tribuf_pkg::IBUF_IDLE: begin
            state_next = fft_tribuf_pkg::IBUF_STREAM;
         end
         fft_tribuf_pkg::IBUF_STREAM: begin
            if (last) begin
               state_next = fft_tribuf_pkg::IBUF_FULL;
            end
         end
         fft_tribuf_pkg::IBUF_FULL: begin
            state_next = fft_tribuf_pkg::IBUF_FULL;
         end
         default: begin
            state_next = fft_tribuf_pkg::IBUF_IDLE;
         end
      endcase
      // new frame starts at every rotation
      if (rotate) begin
         state_next = fft_tribuf_pkg::IBUF_STREAM;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // address and frame bit width
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < `FFT_N; i++) begin
         wr_addr[i] = count[`FFT_N-1-i];
      end
   end

   assign wr_data = {in_imag, in_real};

   assign real_bw   = bit_width(in_real);
   assign imag_bw   = bit_width(in_imag);
   assign sample_bw = (real_bw > imag_bw) ? real_bw : imag_bw;

   // includes a sample written on the rotate edge itself
   assign frame_bw_cap = (wr_en && (sample_bw > max_bw)) ? sample_bw : max_bw;

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= fft_tribuf_pkg::IBUF_IDLE;
         count  <= '0;
         max_bw <= '0;
      end else begin
         state <= state_next;
         if (rotate) begin
            count  <= '0;
            max_bw <= '0;
         end else if (wr_en) begin
            count  <= count + 1'b1;
            max_bw <= frame_bw_cap;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/tribuf_rotation.sv
// triple buffer rotation with run handshake, bank role routing and dma readout
`timescale 1ns/1ps
`default_nettype none

module tribuf_rotation (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          run_req,
   input  wire                          wr_en,
   input  wire fft_tribuf_pkg::addr_t   wr_addr,
   input  wire fft_tribuf_pkg::cword_t  wr_data,
   input  wire fft_tribuf_pkg::bw_t     frame_bw_cap,
   input  wire                          dma_en,
   input  wire fft_tribuf_pkg::addr_t   dma_addr,
   output logic                         run_ack,
   output logic                         rotate,
   output fft_tribuf_pkg::sample_t      dma_real,
   output fft_tribuf_pkg::sample_t      dma_imag,
   output fft_tribuf_pkg::bw_t          frame_bw,
   bank_bus_if.ctrl                     bank0,
   bank_bus_if.ctrl                     bank1,
   bank_bus_if.ctrl                     bank2
);

   fft_tribuf_pkg::phase_t phase;
   logic [2:0]             cap_sel;
   logic [2:0]             rd_sel;
   logic [2:0]             rd_sel_q;
   fft_tribuf_pkg::bw_t    hold_bw;
   fft_tribuf_pkg::cword_t rd_word;

   //////////////////////////////////////////////////////////////////////
   // run handshake and phase
   //////////////////////////////////////////////////////////////////////

   // high for the single cycle before ack rises
   assign rotate = run_req && !run_ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         run_ack <= 1'b0;
      end else if (rotate) begin
         run_ack <= 1'b1;
      end else if (!run_req) begin
         run_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= fft_tribuf_pkg::PHASE_0;
      end else if (rotate) begin
         case (phase)
            fft_tribuf_pkg::PHASE_0: phase <= fft_tribuf_pkg::PHASE_1;
            fft_tribuf_pkg::PHASE_1: phase <= fft_tribuf_pkg::PHASE_2;
            default:                 phase <= fft_tribuf_pkg::PHASE_0;
         endcase
      end
   end

   // capture = phase, readout = phase+1, hold = phase+2 (mod 3)
   always_comb begin
      case (phase)
         fft_tribuf_pkg::PHASE_0: begin
            cap_sel = 3'b001;
            rd_sel  = 3'b010;
         end
         fft_tribuf_pkg::PHASE_1: begin
            cap_sel = 3'b010;
            rd_sel  = 3'b100;
         end
         default: begin
            cap_sel = 3'b100;
            rd_sel  = 3'b001;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // bank routing
   //////////////////////////////////////////////////////////////////////

   // hold bank sees neither selector and stays parked
   assign bank0.we    = wr_en && cap_sel[0];
   assign bank0.waddr = cap_sel[0] ? wr_addr : '0;
   assign bank0.wdata = wr_data;
   assign bank0.raddr = (dma_en && rd_sel[0]) ? dma_addr : '0;

   assign bank1.we    = wr_en && cap_sel[1];
   assign bank1.waddr = cap_sel[1] ? wr_addr : '0;
   assign bank1.wdata = wr_data;
   assign bank1.raddr = (dma_en && rd_sel[1]) ? dma_addr : '0;

   assign bank2.we    = wr_en && cap_sel[2];
   assign bank2.waddr = cap_sel[2] ? wr_addr : '0;
   assign bank2.wdata = wr_data;
   assign bank2.raddr = (dma_en && rd_sel[2]) ? dma_addr : '0;

   // remember which bank the read went to, survives a rotate on the same edge
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_sel_q <= 3'b000;
      end else if (dma_en) begin
         rd_sel_q <= rd_sel;
      end
   end

   always_comb begin
      if (rd_sel_q[0]) begin
         rd_word = bank0.rdata;
      end else if (rd_sel_q[1]) begin
         rd_word = bank1.rdata;
      end else begin
         rd_word = bank2.rdata;
      end
   end

   assign {dma_imag, dma_real} = rd_word;

   // frame bit width moves with its bank: capture -> hold -> readout
   always_ff @(posedge clk) begin
      if (rst) begin
         hold_bw  <= '0;
         frame_bw <= '0;
      end else if (rotate) begin
         hold_bw  <= frame_bw_cap;
         frame_bw <= hold_bw;
      end
   end

endmodule

`default_nettype wire
